//--- common/pe_pkg.sv
package pe_pkg;

    // ========================================
    // datapath widths
    // ========================================

    // activations, weights, psums
    // products are kept at this width too
    // upper product bits dropped
    localparam int DATA_W = 16;

    // configuration word width
    // holds filter_size
    localparam int CFG_W = 8;

    // ========================================
    // scratch pads
    // ========================================

    // entries per operand pad
    // also the largest legal filter_size
    localparam int SPAD_DEPTH = 12;

    // pad address width
    // covers SPAD_DEPTH entries
    localparam int SPAD_AW = 4;

    // ========================================
    // queues
    // ========================================

    // iact, weight and psum-in queues
    localparam int IN_FIFO_DEPTH = 4;

    // psum output queue
    // deeper so finished rows can wait for a slow reader
    localparam int OUT_FIFO_DEPTH = 6;

endpackage

//--- hdl/sync_fifo.sv
module sync_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      write_en,
    input  logic [pe_pkg::DATA_W-1:0] write_data,
    input  logic                      read_en,
    output logic [pe_pkg::DATA_W-1:0] read_data,
    output logic                      full,
    output logic                      empty
);
    import pe_pkg::*;

    // one word per entry
    logic [DATA_W-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_write;
    logic                       do_read;

    // requests outside the legal window are dropped
    assign do_write = write_en && !full;
    assign do_read  = read_en && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);

    // first word falls through
    // head visible without a pop
    assign read_data = mem[rd_ptr];

    // ========================================
    // pointers and occupancy
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                // wrap at DEPTH
                // DEPTH need not be a power of two
                if (wr_ptr == DEPTH - 1)
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                if (rd_ptr == DEPTH - 1)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= write_data;
    end

endmodule

//--- spad/operand_spad.sv
module operand_spad (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [pe_pkg::CFG_W-1:0]   filter_size,
    input  logic                       fifo_empty,
    input  logic [pe_pkg::DATA_W-1:0]  fifo_data,
    output logic                       fifo_read,
    input  logic                       consume,
    input  logic [pe_pkg::SPAD_AW-1:0] rd_addr,
    output logic [pe_pkg::DATA_W-1:0]  rd_data,
    output logic                       loaded
);
    import pe_pkg::*;

    // one row of operands
    logic [DATA_W-1:0]  regs [SPAD_DEPTH];

    // number of entries stored so far
    logic [CFG_W-1:0]   wr_cnt;
    logic [SPAD_AW-1:0] wr_addr;

    // ========================================
    // fill side
    // ========================================

    // next free slot is simply the fill count
    assign wr_addr = wr_cnt[SPAD_AW-1:0];

    // pull from the queue until the row is complete
    assign fifo_read = !fifo_empty && (wr_cnt < filter_size);

    // full row present
    // held until the controller releases it
    assign loaded = (wr_cnt == filter_size) && (filter_size != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_cnt <= '0;
        end else if (consume) begin
            // row done
            // refill starts again at slot 0
            wr_cnt <= '0;
        end else if (fifo_read) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // capture the queue head on the same edge as the pop
    always_ff @(posedge clk) begin
        if (fifo_read)
            regs[wr_addr] <= fifo_data;
    end

    // ========================================
    // read side
    // ========================================

    // combinational read
    // address shared with the other pad
    // and driven by the controller
    assign rd_data = regs[rd_addr];

endmodule

//--- mac/mac_pipeline.sv
module mac_pipeline (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_valid,
    input  logic                      first,
    input  logic                      last,
    input  logic [pe_pkg::DATA_W-1:0] iact,
    input  logic [pe_pkg::DATA_W-1:0] weight,
    input  logic [pe_pkg::DATA_W-1:0] psum_in,
    output logic                      out_valid,
    output logic [pe_pkg::DATA_W-1:0] out_psum
);
    import pe_pkg::*;

    // stage 1 operands
    // held across skipped elements
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] s1_psum;
    logic              s1_valid;
    logic              s1_first;
    logic              s1_last;
    logic              s1_skip;

    // stage 2
    logic [DATA_W-1:0] prod;
    logic [DATA_W-1:0] addend;
    logic [DATA_W-1:0] acc;
    logic              nonzero;

    // zero detect on the raw pad outputs
    assign nonzero = (iact != '0) && (weight != '0);

    // ========================================
    // stage 1 operand capture
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn)
            s1_valid <= 1'b0;
        else
            s1_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        // operands only move when the product matters
        // keeps the multiplier inputs quiet on zeros
        if (in_valid && nonzero) begin
            op_a <= iact;
            op_b <= weight;
        end
        if (in_valid) begin
            s1_first <= first;
            s1_last  <= last;
            s1_skip  <= !nonzero;
        end
        // incoming psum seeds the row
        if (in_valid && first)
            s1_psum <= psum_in;
    end

    // ========================================
    // stage 2 multiply and accumulate
    // ========================================

    // 16 bit context
    // product keeps the low half only
    assign prod = op_a * op_b;

    // skipped element counts as zero
    assign addend = s1_skip ? '0 : prod;

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            if (s1_first)
                acc <= s1_psum + addend;
            else
                acc <= acc + addend;
        end
    end

    // one cycle result strobe for the final element
    always_ff @(posedge clk) begin
        if (!rstn)
            out_valid <= 1'b0;
        else
            out_valid <= s1_valid && s1_last;
    end

    assign out_psum = acc;

endmodule

//--- hdl/pe_controller.sv
module pe_controller (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [pe_pkg::CFG_W-1:0]   filter_size,
    input  logic                       iact_loaded,
    input  logic                       weight_loaded,
    input  logic                       psum_empty,
    input  logic                       out_full,
    output logic [pe_pkg::SPAD_AW-1:0] rd_addr,
    output logic                       in_valid,
    output logic                       first,
    output logic                       last,
    output logic                       psum_pop,
    output logic                       consume
);
    import pe_pkg::*;

    // FSM state
    // high while a row is being issued
    logic               issuing;

    // index of the element issued this cycle
    logic [SPAD_AW-1:0] cnt;

    // results in flight through the mac
    // bit 1 is the older one
    logic [1:0]         pend;

    logic               start;
    logic [CFG_W-1:0]   last_idx;

    // ========================================
    // start and issue
    // ========================================

    // need both rows, a seed psum, room for the result
    // and no older result still in the pipe
    assign start = !issuing && iact_loaded && weight_loaded && !psum_empty
                   && !out_full && (pend == 2'b00);

    // element 0 goes out in the start cycle itself
    assign in_valid = start || issuing;
    assign first    = start;
    assign rd_addr  = cnt;

    assign last_idx = filter_size - 1'b1;
    assign last     = in_valid && ({{(CFG_W - SPAD_AW){1'b0}}, cnt} == last_idx);

    // seed psum already taken on first
    // popped together with the last element
    assign psum_pop = last;

    // ========================================
    // sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issuing <= 1'b0;
            cnt     <= '0;
            pend    <= 2'b00;
            consume <= 1'b0;
        end else begin
            // result reaches the output queue two cycles after last
            pend    <= {pend[0], last};

            // release both pads once the final read is done
            consume <= last;

            if (last) begin
                issuing <= 1'b0;
                cnt     <= '0;
            end else if (in_valid) begin
                issuing <= 1'b1;
                cnt     <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/pe_top.sv
module pe_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [pe_pkg::CFG_W-1:0]  filter_size,
    input  logic                      iact_write_en,
    input  logic [pe_pkg::DATA_W-1:0] data_iact_in,
    output logic                      iact_ready,
    input  logic                      weight_write_en,
    input  logic [pe_pkg::DATA_W-1:0] data_weight_in,
    output logic                      weight_ready,
    input  logic                      psum_write_en,
    input  logic [pe_pkg::DATA_W-1:0] data_psum_in,
    output logic                      psum_ready,
    input  logic                      psum_read_en,
    output logic [pe_pkg::DATA_W-1:0] data_psum_out,
    output logic                      psum_out_valid
);
    import pe_pkg::*;

    // ========================================
    // wires
    // ========================================

    // iact path
    logic [DATA_W-1:0]  iact_head;
    logic               iact_full;
    logic               iact_empty;
    logic               iact_pop;
    logic               iact_loaded;
    logic [DATA_W-1:0]  iact_rd;

    // weight path
    logic [DATA_W-1:0]  weight_head;
    logic               weight_full;
    logic               weight_empty;
    logic               weight_pop;
    logic               weight_loaded;
    logic [DATA_W-1:0]  weight_rd;

    // psum in and out
    logic [DATA_W-1:0]  psum_head;
    logic               psum_in_full;
    logic               psum_in_empty;
    logic               psum_pop;
    logic               psum_out_full;
    logic               psum_out_empty;

    // controller to pads and mac
    logic [SPAD_AW-1:0] rd_addr;
    logic               consume;
    logic               in_valid;
    logic               first;
    logic               last;
    logic               mac_valid;
    logic [DATA_W-1:0]  mac_psum;

    // ready is just room in the channel queue
    assign iact_ready     = !iact_full;
    assign weight_ready   = !weight_full;
    assign psum_ready     = !psum_in_full;
    assign psum_out_valid = !psum_out_empty;

    // ========================================
    // input queues
    // ========================================
    sync_fifo #(.DEPTH(IN_FIFO_DEPTH)) iact_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .write_en   (iact_write_en),
        .write_data (data_iact_in),
        .read_en    (iact_pop),
        .read_data  (iact_head),
        .full       (iact_full),
        .empty      (iact_empty)
    );

    sync_fifo #(.DEPTH(IN_FIFO_DEPTH)) weight_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .write_en   (weight_write_en),
        .write_data (data_weight_in),
        .read_en    (weight_pop),
        .read_data  (weight_head),
        .full       (weight_full),
        .empty      (weight_empty)
    );

    // head feeds the mac directly as the row seed
    sync_fifo #(.DEPTH(IN_FIFO_DEPTH)) psum_in_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .write_en   (psum_write_en),
        .write_data (data_psum_in),
        .read_en    (psum_pop),
        .read_data  (psum_head),
        .full       (psum_in_full),
        .empty      (psum_in_empty)
    );

    // ========================================
    // scratch pads
    // ========================================
    operand_spad iact_spad (
        .clk         (clk),
        .rstn        (rstn),
        .filter_size (filter_size),
        .fifo_empty  (iact_empty),
        .fifo_data   (iact_head),
        .fifo_read   (iact_pop),
        .consume     (consume),
        .rd_addr     (rd_addr),
        .rd_data     (iact_rd),
        .loaded      (iact_loaded)
    );

    operand_spad weight_spad (
        .clk         (clk),
        .rstn        (rstn),
        .filter_size (filter_size),
        .fifo_empty  (weight_empty),
        .fifo_data   (weight_head),
        .fifo_read   (weight_pop),
        .consume     (consume),
        .rd_addr     (rd_addr),
        .rd_data     (weight_rd),
        .loaded      (weight_loaded)
    );

    // ========================================
    // control and datapath
    // ========================================
    pe_controller ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .filter_size   (filter_size),
        .iact_loaded   (iact_loaded),
        .weight_loaded (weight_loaded),
        .psum_empty    (psum_in_empty),
        .out_full      (psum_out_full),
        .rd_addr       (rd_addr),
        .in_valid      (in_valid),
        .first         (first),
        .last          (last),
        .psum_pop      (psum_pop),
        .consume       (consume)
    );

    mac_pipeline mac (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .first     (first),
        .last      (last),
        .iact      (iact_rd),
        .weight    (weight_rd),
        .psum_in   (psum_head),
        .out_valid (mac_valid),
        .out_psum  (mac_psum)
    );

    // finished rows wait here for the reader
    sync_fifo #(.DEPTH(OUT_FIFO_DEPTH)) psum_out_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .write_en   (mac_valid),
        .write_data (mac_psum),
        .read_en    (psum_read_en),
        .read_data  (data_psum_out),
        .full       (psum_out_full),
        .empty      (psum_out_empty)
    );

endmodule

//--- tb/pe_chk.sv
module pe_chk (
    input logic                      clk,
    input logic                      rstn,
    input logic                      iact_write_en,
    input logic                      iact_ready,
    input logic                      weight_write_en,
    input logic                      weight_ready,
    input logic                      psum_write_en,
    input logic                      psum_ready,
    input logic                      psum_read_en,
    input logic                      psum_out_valid,
    input logic [pe_pkg::DATA_W-1:0] data_psum_out
);

    // ========================================
    // input queues only fill through writes
    // ========================================
    iact_ready_fall: assert property (@(posedge clk) disable iff (!rstn)
        $fell(iact_ready) |-> $past(iact_write_en))
        else $error("iact ready fell without a write");

    weight_ready_fall: assert property (@(posedge clk) disable iff (!rstn)
        $fell(weight_ready) |-> $past(weight_write_en))
        else $error("weight ready fell without a write");

    psum_ready_fall: assert property (@(posedge clk) disable iff (!rstn)
        $fell(psum_ready) |-> $past(psum_write_en))
        else $error("psum ready fell without a write");

    // output queue empty right after reset
    out_empty_after_reset: assert property (@(posedge clk)
        !rstn |=> !psum_out_valid)
        else $error("output valid high after reset");

    // head word held while nobody reads it
    out_head_stable: assert property (@(posedge clk) disable iff (!rstn)
        psum_out_valid && !psum_read_en |=> $stable(data_psum_out))
        else $error("output word changed without a read");

endmodule

bind pe_top pe_chk chk0 (.*);

//--- tb/pe_tb.sv
module pe_tb;
    import pe_pkg::*;

    logic              clk;
    logic              rstn;
    logic [CFG_W-1:0]  filter_size;
    logic              iact_write_en;
    logic [DATA_W-1:0] data_iact_in;
    logic              iact_ready;
    logic              weight_write_en;
    logic [DATA_W-1:0] data_weight_in;
    logic              weight_ready;
    logic              psum_write_en;
    logic [DATA_W-1:0] data_psum_in;
    logic              psum_ready;
    logic              psum_read_en;
    logic [DATA_W-1:0] data_psum_out;
    logic              psum_out_valid;

    // ========================================
    // case table
    // ========================================
    string case_name [6];
    int    case_fs [6];
    int    case_rows [6];
    string case_mode [6];
    bit    case_stall [6];

    // results predicted by the model, oldest first
    logic [DATA_W-1:0] expected [$];

    integer seed;
    int     errors;
    int     checks;
    int     timeout_cycles;
    bit     timed_out;
    bit     writer_done;
    bit     saw_ready_low;

    pe_top dut0 (
        .clk             (clk),
        .rstn            (rstn),
        .filter_size     (filter_size),
        .iact_write_en   (iact_write_en),
        .data_iact_in    (data_iact_in),
        .iact_ready      (iact_ready),
        .weight_write_en (weight_write_en),
        .data_weight_in  (data_weight_in),
        .weight_ready    (weight_ready),
        .psum_write_en   (psum_write_en),
        .data_psum_in    (data_psum_in),
        .psum_ready      (psum_ready),
        .psum_read_en    (psum_read_en),
        .data_psum_out   (data_psum_out),
        .psum_out_valid  (psum_out_valid)
    );

    always #50 clk = ~clk;

    task automatic add_case(input int idx, input string name, input int fs, input int rows,
                            input string mode, input bit stall);
        case_name[idx]  = name;
        case_fs[idx]    = fs;
        case_rows[idx]  = rows;
        case_mode[idx]  = mode;
        case_stall[idx] = stall;
    endtask

    // operand pair for element k of row r
    task automatic pick_operands(input string mode, input int k, input int r,
                                 output logic [DATA_W-1:0] a, output logic [DATA_W-1:0] b);
        a = $random(seed);
        b = $random(seed);
        if (mode == "given") begin
            a = k + 1 + r;
            b = 2 * k + 3;
        end else if (mode == "wrap") begin
            // top bits set so every product and the sum overflow
            a = a | 16'h8000;
            b = b | 16'hc000;
        end else if (mode == "zeros") begin
            if (k % 3 == 0)
                a = '0;
            if (k % 3 == 1)
                b = '0;
            if (k % 4 == 3) begin
                a = '0;
                b = '0;
            end
        end
    endtask

    // one word into one channel
    // waits for ready first
    task automatic push_word(input int ch, input logic [DATA_W-1:0] value);
        int waited;
        bit rdy;
        waited = 0;
        rdy    = 1'b0;
        while (!rdy && !timed_out) begin
            @(posedge clk);
            #1;
            iact_write_en   = 1'b0;
            weight_write_en = 1'b0;
            psum_write_en   = 1'b0;
            rdy = (ch == 0) ? iact_ready : (ch == 1) ? weight_ready : psum_ready;
            if (!rdy) begin
                saw_ready_low = 1'b1;
                waited++;
                if (waited > timeout_cycles) begin
                    $display("Timeout: input channel %0d stayed not ready", ch);
                    timed_out = 1'b1;
                end
            end
        end
        if (rdy) begin
            case (ch)
                0: begin
                    iact_write_en = 1'b1;
                    data_iact_in  = value;
                end
                1: begin
                    weight_write_en = 1'b1;
                    data_weight_in  = value;
                end
                default: begin
                    psum_write_en = 1'b1;
                    data_psum_in  = value;
                end
            endcase
        end
    endtask

    // ========================================
    // driver and reference model
    // ========================================
    task automatic feed_rows(input int idx);
        logic [DATA_W-1:0] a_row [SPAD_DEPTH];
        logic [DATA_W-1:0] b_row [SPAD_DEPTH];
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] psum;
        logic [DATA_W-1:0] acc;
        logic [31:0]       full_prod;
        for (int r = 0; r < case_rows[idx]; r++) begin
            psum = $random(seed);
            if (case_mode[idx] == "given")
                psum = 100 + r;
            else if (case_mode[idx] == "wrap")
                psum = 16'hfff0 - r;
            acc = psum;
            for (int k = 0; k < case_fs[idx]; k++) begin
                pick_operands(case_mode[idx], k, r, a, b);
                a_row[k] = a;
                b_row[k] = b;
                // low half of each product
                // sum wraps at 16 bits
                full_prod = a * b;
                acc = acc + full_prod[15:0];
            end
            expected.push_back(acc);
            for (int k = 0; k < case_fs[idx]; k++)
                push_word(0, a_row[k]);
            for (int k = 0; k < case_fs[idx]; k++)
                push_word(1, b_row[k]);
            push_word(2, psum);
        end
        @(posedge clk);
        #1;
        iact_write_en   = 1'b0;
        weight_write_en = 1'b0;
        psum_write_en   = 1'b0;
        writer_done     = 1'b1;
    endtask

    // ========================================
    // reader and compare
    // ========================================
    task automatic collect_results(input int idx);
        int waited;
        int got;
        logic [DATA_W-1:0] exp_val;
        waited = 0;
        got    = 0;
        // stalled reader holds off until every row has been fed
        while (case_stall[idx] && !writer_done && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout: driver did not finish feeding rows in %s", case_name[idx]);
                timed_out = 1'b1;
            end
        end
        waited = 0;
        while (got < case_rows[idx] && !timed_out) begin
            @(posedge clk);
            #1;
            psum_read_en = 1'b0;
            if (psum_out_valid) begin
                checks++;
                assert (expected.size() > 0) else begin
                    errors++;
                    $display("Result appeared with no expected value in %s", case_name[idx]);
                end
                exp_val = (expected.size() > 0) ? expected.pop_front() : '0;
                assert (data_psum_out == exp_val) else begin
                    errors++;
                    $display("Mismatch in %s: expected %h, actual %h",
                             case_name[idx], exp_val, data_psum_out);
                end
                psum_read_en = 1'b1;
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > timeout_cycles) begin
                    $display("Timeout: no result from the PE in %s", case_name[idx]);
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;
        psum_read_en = 1'b0;
    endtask

    initial begin
        seed            = 78162;
        errors          = 0;
        checks          = 0;
        timeout_cycles  = 1000;
        timed_out       = 1'b0;
        clk             = 1'b0;
        rstn            = 1'b0;
        filter_size     = 1;
        iact_write_en   = 1'b0;
        data_iact_in    = '0;
        weight_write_en = 1'b0;
        data_weight_in  = '0;
        psum_write_en   = 1'b0;
        data_psum_in    = '0;
        psum_read_en    = 1'b0;

        add_case(0, "single_given", 3, 1, "given", 1'b0);
        add_case(1, "zero_skip", 5, 3, "zeros", 1'b0);
        add_case(2, "wrap_large", 4, 3, "wrap", 1'b0);
        add_case(3, "backpressure", 6, 7, "random", 1'b1);
        add_case(4, "fs1_random", 1, 4, "random", 1'b0);
        add_case(5, "fs12_random", 12, 3, "random", 1'b0);

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        checks++;
        assert (iact_ready && weight_ready && psum_ready) else begin
            errors++;
            $display("Ready outputs are not all high after reset");
        end
        assert (!psum_out_valid) else begin
            errors++;
            $display("Output valid is high after reset");
        end

        for (int idx = 0; idx < 6; idx++) begin
            if (!timed_out) begin
                // PE is idle here
                // row length may change now
                filter_size   = case_fs[idx];
                writer_done   = 1'b0;
                saw_ready_low = 1'b0;
                fork
                    feed_rows(idx);
                    collect_results(idx);
                join
                repeat (4) @(posedge clk);
                #1;
                checks++;
                assert (!psum_out_valid) else begin
                    errors++;
                    $display("Extra result left in the output queue after %s", case_name[idx]);
                end
                assert (!case_stall[idx] || saw_ready_low) else begin
                    errors++;
                    $display("Ready never dropped during %s", case_name[idx]);
                end
            end
        end

        $display("checks=%0d errors=%0d timeout=%0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- pe_row_mac.f
common/pe_pkg.sv
hdl/sync_fifo.sv
spad/operand_spad.sv
mac/mac_pipeline.sv
hdl/pe_controller.sv
hdl/pe_top.sv
tb/pe_chk.sv
tb/pe_tb.sv
